//--- tb.f
+incdir+.
proc_pkg.sv
proc_bus_if.sv
instr_fetch.sv
reg_decode.sv
exec_alu.sv
mem_writeback.sv
multicycle_ctrl.sv
proc_top.sv
tb_clk_gen.sv
tb_proc.sv

//--- tb_proc.sv
`default_nettype none

`include "proc_cfg.svh"

module tb_proc;

  import proc_pkg::*;

  // Cycle limit for one program run
  localparam int RUN_LIMIT = 2000;

  logic                    clk;
  logic                    rst;
  logic                    start;
  logic                    prog_we;
  logic [`PROC_PC_W-1:0]   prog_addr;
  logic [`PROC_DATA_W-1:0] prog_data;
  logic                    out_valid;
  logic [`PROC_DATA_W-1:0] out_data;
  flags_t                  flags;
  logic                    busy;
  logic                    halted;

  // Program under test and what the DUT emitted
  logic [`PROC_DATA_W-1:0] prog_q[$];
  logic [`PROC_DATA_W-1:0] out_q[$];
  int                      out_cyc[$];
  int                      fetch_cyc;

  // Instruction-level reference model
  logic [`PROC_DATA_W-1:0] m_regs [`PROC_REGS];
  logic [`PROC_DATA_W-1:0] m_mem [`PROC_DMEM_DEPTH];
  flags_t                  m_flags;
  logic [`PROC_DATA_W-1:0] exp_q[$];
  // Instructions executed up to and including HLT
  int                      m_steps;

  tb_clk_gen #(.PERIOD(8)) i_clk_gen (.clk(clk));

  proc_top i_proc_top (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .flags     (flags),
    .busy      (busy),
    .halted    (halted)
  );

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_error("Value mismatch");
    end
  endtask

  // Register format word
  function automatic logic [`PROC_DATA_W-1:0] reg_word(opcode_e op, int d, int s, int s2);
    instr_u w;
    w.r_fmt.op     = op;
    w.r_fmt.dest   = d[2:0];
    w.r_fmt.src    = s[2:0];
    w.r_fmt.src2   = s2[2:0];
    w.r_fmt.unused = 2'b00;
    return w;
  endfunction

  // Immediate format word, low 5 bits of imm kept
  function automatic logic [`PROC_DATA_W-1:0] imm_word(opcode_e op, int d, int s, int imm);
    instr_u w;
    w.i_fmt.op   = op;
    w.i_fmt.dest = d[2:0];
    w.i_fmt.src  = s[2:0];
    w.i_fmt.imm  = imm[4:0];
    return w;
  endfunction

  function automatic int rand_imm();
    return $urandom_range(31, 0);
  endfunction

  // Two cycles of reset; model registers and flags clear too
  task automatic apply_reset();
    @(posedge clk);
    rst     <= 1'b1;
    start   <= 1'b0;
    prog_we <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < `PROC_REGS; i++)
      m_regs[i] = '0;
    m_flags = '0;
  endtask

  // One word per cycle through the load port
  task automatic load_program();
    foreach (prog_q[i])
    begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= `PROC_PC_W'(i);
      prog_data <= prog_q[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // Executes prog_q by the ISA rules, expected outputs into exp_q
  task automatic run_model();
    int                      pc;
    int                      steps;
    logic [`PROC_DATA_W-1:0] w;
    logic [`PROC_DATA_W-1:0] a;
    logic [`PROC_DATA_W-1:0] b;
    logic [`PROC_DATA_W-1:0] imm;
    logic [`PROC_DATA_W-1:0] ea;
    logic [`PROC_DATA_W:0]   r;
    logic [2:0]              d;
    bit                      alu;
    bit                      stop;
    exp_q.delete();
    pc    = 0;
    steps = 0;
    stop  = 1'b0;
    while (!stop && steps < RUN_LIMIT)
    begin
      w     = prog_q[pc];
      pc    = (pc + 1) % `PROC_IMEM_DEPTH;
      steps = steps + 1;
      d     = w[10:8];
      a     = m_regs[w[7:5]];
      b     = m_regs[w[4:2]];
      imm   = {{(`PROC_DATA_W-5){w[4]}}, w[4:0]};
      ea    = a + imm;
      r     = '0;
      // ADD through ADDI touch the flags
      alu   = (w[15:11] inside {[OP_ADD:OP_ADDI]});
      case (w[15:11])
        OP_ADD:  r = {1'b0, a} + {1'b0, b};
        // Top bit is the borrow
        OP_SUB:  r = {(a < b), a - b};
        OP_AND:  r = {1'b0, a & b};
        OP_OR:   r = {1'b0, a | b};
        OP_XOR:  r = {1'b0, a ^ b};
        OP_ADDI: r = {1'b0, a} + {1'b0, imm};
        OP_LD:
        begin
          if (d != 0)
            m_regs[d] = m_mem[ea[7:0]];
        end
        OP_ST:   m_mem[ea[7:0]] = m_regs[d];
        OP_OUT:  exp_q.push_back(a);
        OP_HLT:  stop = 1'b1;
        default: r = '0;
      endcase
      if (alu)
      begin
        if (d != 0)
          m_regs[d] = r[`PROC_DATA_W-1:0];
        m_flags.zero  = (r[`PROC_DATA_W-1:0] == '0);
        m_flags.neg   = r[`PROC_DATA_W-1];
        m_flags.carry = r[`PROC_DATA_W];
      end
    end
    m_steps = steps;
  endtask

  // Start strobe, then sample every cycle at the falling edge
  // Cycle 1 is the one in which start is high
  task automatic run_until_halt();
    int cyc;
    int halt_cyc;
    bit done;
    out_q.delete();
    out_cyc.delete();
    fetch_cyc = 0;
    cyc       = 0;
    done      = 1'b0;
    // Five cycles per instruction from the first FETCH in cycle 2
    halt_cyc  = 5 * m_steps + 2;
    @(posedge clk);
    start <= 1'b1;
    while (!done)
    begin
      @(negedge clk);
      cyc = cyc + 1;
      if (busy && fetch_cyc == 0)
        fetch_cyc = cyc;
      if (out_valid)
      begin
        out_q.push_back(out_data);
        out_cyc.push_back(cyc);
      end
      // Idle in cycle 1, busy until HALT begins
      check_val("busy", busy, (cyc >= 2) && (cyc < halt_cyc));
      check_val("halted", halted, cyc >= halt_cyc);
      if (halted)
        done = 1'b1;
      else if (cyc >= RUN_LIMIT)
        stop_on_error("Processor did not halt within the cycle limit");
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  // Load, model, run, compare outputs and flags
  task automatic run_program();
    load_program();
    run_model();
    run_until_halt();
    check_val("out count", out_q.size(), exp_q.size());
    foreach (exp_q[i])
      check_val($sformatf("out_data[%0d]", i), out_q[i], exp_q[i]);
    check_val("flags", flags, m_flags);
  endtask

  task automatic test_reset_state();
    apply_reset();
    @(negedge clk);
    check_val("busy", busy, 1'b0);
    check_val("halted", halted, 1'b0);
    check_val("out_valid", out_valid, 1'b0);
    check_val("flags", flags, 3'b000);
    check_val("out_data", out_data, '0);
    prog_q.delete();
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
  endtask

  // Random operands in r1 and r2, each op result emitted
  task automatic test_alu_ops();
    opcode_e ops [5];
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    for (int round = 0; round < 3; round++)
    begin
      apply_reset();
      prog_q.delete();
      prog_q.push_back(imm_word(OP_ADDI, 1, 0, rand_imm()));
      prog_q.push_back(imm_word(OP_ADDI, 1, 1, rand_imm()));
      prog_q.push_back(imm_word(OP_ADDI, 2, 0, rand_imm()));
      prog_q.push_back(reg_word(OP_ADD, 2, 2, 1));
      prog_q.push_back(imm_word(OP_ADDI, 2, 2, rand_imm()));
      for (int k = 0; k < 5; k++)
      begin
        prog_q.push_back(reg_word(ops[k], 3 + k, 1, 2));
        prog_q.push_back(imm_word(OP_OUT, 0, 3 + k, 0));
      end
      prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
      run_program();
    end
  endtask

  // Last ALU op decides the flags; OUT and ST after it change nothing
  task automatic flag_case(input int a_imm, input int b_imm, input opcode_e op,
                           input logic [2:0] expected);
    apply_reset();
    prog_q.delete();
    prog_q.push_back(imm_word(OP_ADDI, 1, 0, a_imm));
    prog_q.push_back(imm_word(OP_ADDI, 2, 0, b_imm));
    prog_q.push_back(reg_word(op, 3, 1, 2));
    prog_q.push_back(imm_word(OP_OUT, 0, 3, 0));
    prog_q.push_back(imm_word(OP_ST, 3, 0, 4));
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
    check_val("flags {zero,neg,carry}", flags, expected);
  endtask

  task automatic test_flags();
    flag_case(5, 5, OP_SUB, 3'b100);
    flag_case(-5, 0, OP_ADD, 3'b010);
    flag_case(-1, 2, OP_ADD, 3'b001);
    // Borrow with a negative difference
    flag_case(1, 2, OP_SUB, 3'b011);
  endtask

  // Base 0xfff0 and base 0x00f0 share their low 8 address bits
  task automatic test_memory();
    apply_reset();
    prog_q.delete();
    prog_q.push_back(imm_word(OP_ADDI, 1, 0, -16));
    prog_q.push_back(imm_word(OP_ADDI, 2, 0, rand_imm()));
    prog_q.push_back(imm_word(OP_ADDI, 3, 0, rand_imm()));
    prog_q.push_back(reg_word(OP_SUB, 4, 2, 3));
    prog_q.push_back(imm_word(OP_ST, 2, 1, -16));
    prog_q.push_back(imm_word(OP_ST, 3, 1, 3));
    prog_q.push_back(imm_word(OP_ST, 4, 1, 15));
    // r7 = 15 doubled four times, 0x00f0
    prog_q.push_back(imm_word(OP_ADDI, 7, 0, 15));
    for (int k = 0; k < 4; k++)
      prog_q.push_back(reg_word(OP_ADD, 7, 7, 7));
    prog_q.push_back(imm_word(OP_LD, 5, 7, 3));
    prog_q.push_back(imm_word(OP_LD, 6, 1, -16));
    // r0 must stay zero
    prog_q.push_back(imm_word(OP_LD, 0, 1, 15));
    prog_q.push_back(imm_word(OP_LD, 2, 7, 15));
    prog_q.push_back(imm_word(OP_OUT, 0, 5, 0));
    prog_q.push_back(imm_word(OP_OUT, 0, 6, 0));
    prog_q.push_back(imm_word(OP_OUT, 0, 0, 0));
    prog_q.push_back(imm_word(OP_OUT, 0, 2, 0));
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
    check_val("r0 via OUT", out_q[2], '0);
  endtask

  // FETCH in cycle 2, write-back of the first OUT in cycle 6
  task automatic test_timing();
    apply_reset();
    prog_q.delete();
    prog_q.push_back(imm_word(OP_OUT, 0, 0, 0));
    prog_q.push_back(imm_word(OP_OUT, 0, 0, 0));
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
    check_val("first busy cycle", fetch_cyc, 2);
    check_val("first out_valid cycle", out_cyc[0], 6);
    check_val("out_valid spacing", out_cyc[1] - out_cyc[0], 5);
  endtask

  task automatic test_halt_and_reload();
    apply_reset();
    prog_q.delete();
    prog_q.push_back(imm_word(OP_ADDI, 1, 0, rand_imm()));
    prog_q.push_back(imm_word(OP_OUT, 0, 1, 0));
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
    // Start pulses have no effect in HALT
    for (int i = 0; i < 12; i++)
    begin
      @(posedge clk);
      start <= (i % 3 == 0);
      @(negedge clk);
      check_val("halted", halted, 1'b1);
      check_val("busy", busy, 1'b0);
      check_val("out_valid", out_valid, 1'b0);
    end
    apply_reset();
    @(negedge clk);
    check_val("halted", halted, 1'b0);
    prog_q.delete();
    prog_q.push_back(imm_word(OP_ADDI, 5, 0, rand_imm()));
    prog_q.push_back(imm_word(OP_ADDI, 6, 0, rand_imm()));
    prog_q.push_back(reg_word(OP_XOR, 7, 5, 6));
    prog_q.push_back(imm_word(OP_OUT, 0, 7, 0));
    prog_q.push_back(reg_word(OP_ADD, 1, 7, 5));
    prog_q.push_back(imm_word(OP_OUT, 0, 1, 0));
    prog_q.push_back(imm_word(OP_HLT, 0, 0, 0));
    run_program();
  endtask

  initial
  begin
    rst       = 1'b1;
    start     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(32'hd866_75d9));
    test_reset_state();
    test_alu_ops();
    test_flags();
    test_memory();
    test_timing();
    test_halt_and_reload();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  // Free-running clock, starts low
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- proc_top.sv
`default_nettype none

`include "proc_cfg.svh"

module proc_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic                    prog_we,
  input  logic [`PROC_PC_W-1:0]   prog_addr,
  input  logic [`PROC_DATA_W-1:0] prog_data,
  output logic                    out_valid,
  output logic [`PROC_DATA_W-1:0] out_data,
  output proc_pkg::flags_t        flags,
  output logic                    busy,
  output logic                    halted
);

  import proc_pkg::*;

  stage_e                        stage;
  instr_u                        instr;
  // Register write from the output side
  logic                          wb_we;
  logic [$clog2(`PROC_REGS)-1:0] wb_addr;
  logic [`PROC_DATA_W-1:0]       wb_data;

  // Decoded op and result between stages
  proc_bus_if bus ();

  // Input side
  instr_fetch i_instr_fetch (
    .clk       (clk),
    .rst       (rst),
    .stage     (stage),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .instr     (instr)
  );

  // Processing part
  reg_decode i_reg_decode (
    .clk     (clk),
    .rst     (rst),
    .stage   (stage),
    .instr   (instr),
    .wb_we   (wb_we),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .bus     (bus.dec)
  );

  exec_alu i_exec_alu (
    .clk   (clk),
    .rst   (rst),
    .stage (stage),
    .bus   (bus.exe),
    .flags (flags)
  );

  // Output side
  mem_writeback i_mem_writeback (
    .clk       (clk),
    .rst       (rst),
    .stage     (stage),
    .bus       (bus.mem),
    .wb_we     (wb_we),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  // Sequencer
  multicycle_ctrl i_multicycle_ctrl (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .bus    (bus.ctl),
    .stage  (stage),
    .busy   (busy),
    .halted (halted)
  );

endmodule

`default_nettype wire

//--- multicycle_ctrl.sv
`default_nettype none

module multicycle_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  proc_bus_if.ctl          bus,
  output proc_pkg::stage_e stage,
  output logic             busy,
  output logic             halted
);

  import proc_pkg::*;

  stage_e next_stage;

  // Five phases per instruction
  always_comb
  begin
    case (stage)
      // Start strobe only counts here
      IDLE:      next_stage = start ? FETCH : IDLE;
      FETCH:     next_stage = DECODE;
      DECODE:    next_stage = EXECUTE;
      EXECUTE:   next_stage = MEMORY;
      MEMORY:    next_stage = WRITEBACK;
      // HLT parks the core after its own write-back
      WRITEBACK: next_stage = (bus.op == OP_HLT) ? HALT : FETCH;
      HALT:      next_stage = HALT;
      default:   next_stage = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      stage <= IDLE;
    end
    else
    begin
      stage <= next_stage;
    end
  end

  // Status
  assign busy   = (stage != IDLE) && (stage != HALT);
  assign halted = (stage == HALT);

  // Only reset gets out of halt
  a_halt_sticky : assert property (@(posedge clk) disable iff (rst)
    stage == HALT |=> stage == HALT);

endmodule

`default_nettype wire

//--- mem_writeback.sv
`default_nettype none

`include "proc_cfg.svh"

module mem_writeback (
  input  logic                          clk,
  input  logic                          rst,
  input  proc_pkg::stage_e              stage,
  proc_bus_if.mem                       bus,
  output logic                          wb_we,
  output logic [$clog2(`PROC_REGS)-1:0] wb_addr,
  output logic [`PROC_DATA_W-1:0]       wb_data,
  output logic                          out_valid,
  output logic [`PROC_DATA_W-1:0]       out_data
);

  import proc_pkg::*;

  localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

  // Data store, not cleared by reset
  logic [`PROC_DATA_W-1:0] dmem [`PROC_DMEM_DEPTH];
  logic [`PROC_DATA_W-1:0] ld_data;
  logic [DMEM_AW-1:0]      addr;

  // Upper result bits ignored, address wraps at 256
  assign addr = bus.result[DMEM_AW-1:0];

  // Memory access
  always_ff @(posedge clk)
  begin
    if (stage == MEMORY)
    begin
      if (bus.op == OP_ST)
      begin
        dmem[addr] <= bus.store_data;
      end
      // Read every memory phase, used by LD only
      ld_data <= dmem[addr];
    end
  end

  // Output port
  // Set up in the memory phase so the strobe covers write-back
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end
    else
    begin
      out_valid <= (stage == MEMORY) && (bus.op == OP_OUT);
      if (stage == MEMORY && bus.op == OP_OUT)
      begin
        out_data <= bus.result;
      end
    end
  end

  // Write-back selection
  assign wb_we   = (stage == WRITEBACK) && bus.wr_reg;
  assign wb_addr = bus.dest;
  assign wb_data = (bus.op == OP_LD) ? ld_data : bus.result;

  // Strobe must line up with the sequencer's write-back phase
  a_out_phase : assert property (@(posedge clk) disable iff (rst)
    out_valid |-> stage == WRITEBACK);

endmodule

`default_nettype wire

//--- exec_alu.sv
`default_nettype none

`include "proc_cfg.svh"

module exec_alu (
  input  logic             clk,
  input  logic             rst,
  input  proc_pkg::stage_e stage,
  proc_bus_if.exe          bus,
  output proc_pkg::flags_t flags
);

  import proc_pkg::*;

  // One extra bit for carry and borrow
  logic [`PROC_DATA_W:0]   sum;
  logic [`PROC_DATA_W:0]   diff;
  logic [`PROC_DATA_W-1:0] alu_out;
  logic                    carry;

  always_comb
  begin
    sum     = {1'b0, bus.opa} + {1'b0, bus.opb};
    diff    = {1'b0, bus.opa} - {1'b0, bus.opb};
    alu_out = '0;
    carry   = 1'b0;
    case (bus.op)
      OP_ADD, OP_ADDI:
      begin
        alu_out = sum[`PROC_DATA_W-1:0];
        carry   = sum[`PROC_DATA_W];
      end
      OP_SUB:
      begin
        alu_out = diff[`PROC_DATA_W-1:0];
        // Top bit set on borrow
        carry   = diff[`PROC_DATA_W];
      end
      OP_AND: alu_out = bus.opa & bus.opb;
      OP_OR:  alu_out = bus.opa | bus.opb;
      OP_XOR: alu_out = bus.opa ^ bus.opb;
      // Effective address, base plus offset
      OP_LD, OP_ST: alu_out = sum[`PROC_DATA_W-1:0];
      // Port value passes straight through
      OP_OUT: alu_out = bus.opa;
      default: alu_out = '0;
    endcase
  end

  // Result latch
  always_ff @(posedge clk)
  begin
    if (stage == EXECUTE)
    begin
      bus.result <= alu_out;
    end
  end

  // Condition codes
  // Held through loads, stores, OUT and NOP
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      flags <= '0;
    end
    else if (stage == EXECUTE && op_is_alu(bus.op))
    begin
      flags.zero  <= (alu_out == '0);
      flags.neg   <= alu_out[`PROC_DATA_W-1];
      flags.carry <= carry;
    end
  end

endmodule

`default_nettype wire

//--- reg_decode.sv
`default_nettype none

`include "proc_cfg.svh"

module reg_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  proc_pkg::stage_e              stage,
  input  proc_pkg::instr_u              instr,
  input  logic                          wb_we,
  input  logic [$clog2(`PROC_REGS)-1:0] wb_addr,
  input  logic [`PROC_DATA_W-1:0]       wb_data,
  proc_bus_if.dec                       bus
);

  import proc_pkg::*;

  logic [`PROC_DATA_W-1:0] rf [`PROC_REGS];
  logic [`PROC_DATA_W-1:0] imm_ext;
  logic [`PROC_DATA_W-1:0] opb_sel;

  // Immediate view, sign extended
  assign imm_ext = {{(`PROC_DATA_W-5){instr.i_fmt.imm[4]}}, instr.i_fmt.imm};

  // Second operand
  // Register view for reg-reg ops, immediate view for ADDI, LD, ST
  always_comb
  begin
    case (instr.r_fmt.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: opb_sel = rf[instr.r_fmt.src2];
      OP_ADDI, OP_LD, OP_ST:                 opb_sel = imm_ext;
      default:                               opb_sel = '0;
    endcase
  end

  // Register file with write-back port
  // r0 is never written so it keeps reading zero
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `PROC_REGS; i++)
      begin
        rf[i] <= '0;
      end
    end
    else if (stage == WRITEBACK && wb_we && wb_addr != '0)
    begin
      rf[wb_addr] <= wb_data;
    end
  end

  // Decoded control fields
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      bus.op     <= OP_NOP;
      bus.wr_reg <= 1'b0;
    end
    else if (stage == DECODE)
    begin
      bus.op     <= instr.r_fmt.op;
      // ALU results and loads go back to the register file
      bus.wr_reg <= op_is_alu(instr.r_fmt.op) || instr.r_fmt.op == OP_LD;
    end
  end

  // Operand latch
  always_ff @(posedge clk)
  begin
    if (stage == DECODE)
    begin
      bus.dest       <= instr.i_fmt.dest;
      bus.opa        <= rf[instr.i_fmt.src];
      bus.opb        <= opb_sel;
      // Store data comes from the dest field
      bus.store_data <= (instr.r_fmt.op == OP_ST) ? rf[instr.i_fmt.dest] : '0;
    end
  end

  // Write-back request only from the output side in its own phase
  a_wb_phase : assert property (@(posedge clk) disable iff (rst)
    wb_we |-> stage == WRITEBACK);

endmodule

`default_nettype wire

//--- instr_fetch.sv
`default_nettype none

`include "proc_cfg.svh"

module instr_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  proc_pkg::stage_e        stage,
  input  logic                    prog_we,
  input  logic [`PROC_PC_W-1:0]   prog_addr,
  input  logic [`PROC_DATA_W-1:0] prog_data,
  output proc_pkg::instr_u        instr
);

  import proc_pkg::*;

  // Program store
  // Contents survive reset
  logic [`PROC_DATA_W-1:0] imem [`PROC_IMEM_DEPTH];
  logic [`PROC_PC_W-1:0]   pc;

  // Load port
  // Writes only land while the core is idle
  always_ff @(posedge clk)
  begin
    if (prog_we && stage == IDLE)
    begin
      imem[prog_addr] <= prog_data;
    end
  end

  // PC and instruction register
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc    <= '0;
      instr <= '0;
    end
    else if (stage == FETCH)
    begin
      instr <= instr_u'(imem[pc]);
      // Rolls over at 64 words
      pc    <= pc + 1'b1;
    end
  end

  // Loader must wait for the sequencer to be idle
  a_prog_idle : assert property (@(posedge clk) disable iff (rst)
    prog_we |-> stage == IDLE);

endmodule

`default_nettype wire

//--- proc_bus_if.sv
`default_nettype none

`include "proc_cfg.svh"

interface proc_bus_if;

  import proc_pkg::*;

  // Decoded operation, held from decode until the next decode
  opcode_e                        op;
  logic [$clog2(`PROC_REGS)-1:0]  dest;
  logic [`PROC_DATA_W-1:0]        opa;
  logic [`PROC_DATA_W-1:0]        opb;
  // Value of the destination register, used by ST only
  logic [`PROC_DATA_W-1:0]        store_data;
  // Register write needed at write-back
  logic                           wr_reg;

  // ALU output or memory address
  logic [`PROC_DATA_W-1:0]        result;

  modport dec (output op, dest, opa, opb, store_data, wr_reg);
  modport exe (input op, opa, opb, output result);
  modport mem (input op, dest, result, store_data, wr_reg);
  // Sequencer only looks at HLT
  modport ctl (input op);

endinterface

`default_nettype wire

//--- proc_pkg.sv
`default_nettype none

package proc_pkg;

  // Operation codes in the top five bits of a word
  // Codes not listed here behave as NOP
  typedef enum logic [4:0] {
    OP_NOP  = 5'd0,
    OP_ADD  = 5'd1,
    OP_SUB  = 5'd2,
    OP_AND  = 5'd3,
    OP_OR   = 5'd4,
    OP_XOR  = 5'd5,
    OP_ADDI = 5'd6,
    OP_LD   = 5'd7,
    OP_ST   = 5'd8,
    OP_OUT  = 5'd9,
    OP_HLT  = 5'd10
  } opcode_e;

  // Controller states, one per instruction phase
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    FETCH     = 3'd1,
    DECODE    = 3'd2,
    EXECUTE   = 3'd3,
    MEMORY    = 3'd4,
    WRITEBACK = 3'd5,
    HALT      = 3'd6
  } stage_e;

  // Register format
  typedef struct packed {
    opcode_e    op;
    logic [2:0] dest;
    logic [2:0] src;
    logic [2:0] src2;
    logic [1:0] unused;
  } r_fmt_t;

  // Immediate format, 5-bit signed offset in the low bits
  typedef struct packed {
    opcode_e    op;
    logic [2:0] dest;
    logic [2:0] src;
    logic [4:0] imm;
  } i_fmt_t;

  // Same word, two decodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  // Condition codes
  typedef struct packed {
    logic zero;
    logic neg;
    logic carry;
  } flags_t;

  // ALU-type ops, ADD through ADDI
  // These write a register and update the flags
  function automatic logic op_is_alu(opcode_e op);
    return (op >= OP_ADD) && (op <= OP_ADDI);
  endfunction

endpackage

`default_nettype wire

//--- proc_cfg.svh
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Width of data words and of instruction words
`define PROC_DATA_W 16

// Register file entries
// r0 is hardwired to zero
`define PROC_REGS 8

// Instruction memory words
`define PROC_IMEM_DEPTH 64

// Data memory words, addressed by the low 8 result bits
`define PROC_DMEM_DEPTH 256

// Program counter width
// Wraps at the instruction memory depth
`define PROC_PC_W 6

`endif
